//--- ahbl_matrix.f
rtl/ahbl_bus_pkg.sv
rtl/ahbl_map_pkg.sv
rtl/ahbl_master_stage.sv
rtl/ahbl_slave_stage.sv
rtl/ahbl_matrix.sv
verif/ahbl_mem_slave.sv
verif/ahbl_matrix_tb.sv

//--- Bender.yml
package:
  name: ahbl_matrix

sources:
  - rtl/ahbl_bus_pkg.sv
  - rtl/ahbl_map_pkg.sv
  - rtl/ahbl_master_stage.sv
  - rtl/ahbl_slave_stage.sv
  - rtl/ahbl_matrix.sv
  - target: simulation
    files:
      - verif/ahbl_mem_slave.sv
      - verif/ahbl_matrix_tb.sv

//--- verif/ahbl_matrix_tb.sv
//**********************************************************************
// Directed testbench for the two-master AHB-Lite matrix.
// Master transfers are single words without pipelining, so an address
// phase starts only after the previous data phase of that master ends.
// Slave wait states are drawn from $urandom with a fixed seed.
// Inputs change 1 ns after the rising edge, outputs are sampled on the
// falling edge.
//**********************************************************************
`timescale 1ns/1ps

module ahbl_matrix_tb;
	import ahbl_bus_pkg::*;
	import ahbl_map_pkg::*;

	localparam int SEED     = 12511;
	localparam int TIMEOUT  = 64;   // Cycles allowed for any single wait
	localparam int WAIT_MAX = 3;    // Slave wait states per transfer

	logic    hclk;
	logic    rst_n;
	logic    remap_m0;
	haddr_t  haddr_m [NUM_MASTERS];
	htrans_t htrans_m [NUM_MASTERS];
	logic    hwrite_m [NUM_MASTERS];
	hsize_t  hsize_m [NUM_MASTERS];
	hburst_t hburst_m [NUM_MASTERS];
	logic    hmastlock_m [NUM_MASTERS];
	hdata_t  hwdata_m [NUM_MASTERS];
	hdata_t  hrdata_m [NUM_MASTERS];
	logic    hready_m [NUM_MASTERS];
	hresp_t  hresp_m [NUM_MASTERS];

	wire slot_vec_t hsel_s;
	wire slot_vec_t hwrite_s;
	wire slot_vec_t hmastlock_s;
	wire slot_vec_t hready_s;
	wire slot_vec_t hreadyout_s;
	haddr_t  haddr_s [NUM_SLOTS];
	htrans_t htrans_s [NUM_SLOTS];
	hsize_t  hsize_s [NUM_SLOTS];
	hburst_t hburst_s [NUM_SLOTS];
	hdata_t  hwdata_s [NUM_SLOTS];
	hdata_t  hrdata_s [NUM_SLOTS];
	hresp_t  hresp_s [NUM_SLOTS];
	logic [1:0] wait_draw [NUM_SLOTS];

	// Outcome of the last transfer of each master
	hdata_t last_rdata [NUM_MASTERS];
	hresp_t first_resp [NUM_MASTERS];   // First data-phase cycle
	hresp_t last_resp [NUM_MASTERS];
	int     last_waits [NUM_MASTERS];

	int   checks = 0;
	int   mismatches = 0;
	int   failures = 0;
	logic lock_held;

	ahbl_matrix DUT (
		.*,
		.haddr_m0     (haddr_m[0]),
		.htrans_m0    (htrans_m[0]),
		.hwrite_m0    (hwrite_m[0]),
		.hsize_m0     (hsize_m[0]),
		.hburst_m0    (hburst_m[0]),
		.hmastlock_m0 (hmastlock_m[0]),
		.hwdata_m0    (hwdata_m[0]),
		.hrdata_m0    (hrdata_m[0]),
		.hready_m0    (hready_m[0]),
		.hresp_m0     (hresp_m[0]),
		.haddr_m1     (haddr_m[1]),
		.htrans_m1    (htrans_m[1]),
		.hwrite_m1    (hwrite_m[1]),
		.hsize_m1     (hsize_m[1]),
		.hburst_m1    (hburst_m[1]),
		.hmastlock_m1 (hmastlock_m[1]),
		.hwdata_m1    (hwdata_m[1]),
		.hrdata_m1    (hrdata_m[1]),
		.hready_m1    (hready_m[1]),
		.hresp_m1     (hresp_m[1])
	);

	for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_mem
		ahbl_mem_slave u_mem (
			.hclk        (hclk),
			.rst_n       (rst_n),
			.hsel        (hsel_s[s]),
			.haddr       (haddr_s[s]),
			.htrans      (htrans_s[s]),
			.hwrite      (hwrite_s[s]),
			.hwdata      (hwdata_s[s]),
			.hready      (hready_s[s]),
			.wait_states (wait_draw[s]),
			.hrdata      (hrdata_s[s]),
			.hreadyout   (hreadyout_s[s]),
			.hresp       (hresp_s[s])
		);
	end

	initial begin
		hclk = 1'b0;
		forever #2 hclk = ~hclk;
	end

	// New wait-state draw for every slave each cycle
	initial begin
		for (int s = 0; s < NUM_SLOTS; s++) begin
			wait_draw[s] = 2'd0;
		end
		void'($urandom(SEED));
		forever begin
			@(posedge hclk);
			#1;
			for (int s = 0; s < NUM_SLOTS; s++) begin
				wait_draw[s] = 2'($urandom % (WAIT_MAX + 1));
			end
		end
	end

	task automatic abort_run(input string why);
		failures++;
		$display("Timeout: %s", why);
		$display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		$display("=== FAIL ===");
		$finish;
	endtask

	task automatic check_data(input string name, input hdata_t exp, input hdata_t act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch in %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input hresp_t exp, input hresp_t act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch in %s: expected hresp %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_slots(input string name, input slot_vec_t exp, input slot_vec_t act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch in %s: expected slots %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_ready(input string name, input master_vec_t exp,
			input master_vec_t act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch in %s: expected hready %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			mismatches++;
			$display("Mismatch in %s: expected %0d wait cycles, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_trans(input string name, input htrans_t exp, input htrans_t act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch in %s: expected htrans %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_size(input string name, input hsize_t exp, input hsize_t act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch in %s: expected hsize %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_burst(input string name, input hburst_t exp, input hburst_t act);
		checks++;
		if (act !== exp) begin
			mismatches++;
			$display("Mismatch in %s: expected hburst %b, actual %b", name, exp, act);
		end
	endtask

	// Address phases taken by a slave carry the master's single-word attributes
	always @(negedge hclk) begin
		if (rst_n) begin
			for (int s = 0; s < NUM_SLOTS; s++) begin
				if (hsel_s[s] && hready_s[s]) begin
					check_trans("address phase", HTRANS_NONSEQ, htrans_s[s]);
					check_size("address phase", 3'b010, hsize_s[s]);     // Word
					check_burst("address phase", 3'b000, hburst_s[s]);   // SINGLE
				end
			end
			check_slots("address lock",
				hsel_s & hready_s & {NUM_SLOTS{hmastlock_m[0] | hmastlock_m[1]}},
				hsel_s & hready_s & hmastlock_s);
		end
	end

	task automatic bus_xfer(input int m, input haddr_t addr, input logic write,
			input hdata_t wdata, input logic lock);
		int n;
		@(posedge hclk);
		#1;
		haddr_m[m]     = addr;
		htrans_m[m]    = HTRANS_NONSEQ;
		hwrite_m[m]    = write;
		hmastlock_m[m] = lock;   // Stays up until the caller drops it
		n = 0;
		@(negedge hclk);
		while (!hready_m[m]) begin
			n++;
			if (n > TIMEOUT) abort_run("address phase was never accepted");
			@(negedge hclk);
		end
		@(posedge hclk);
		#1;
		htrans_m[m] = HTRANS_IDLE;
		hwdata_m[m] = wdata;
		n = 0;
		@(negedge hclk);
		first_resp[m] = hresp_m[m];
		while (!hready_m[m]) begin
			n++;
			if (n > TIMEOUT) abort_run("data phase never completed");
			@(negedge hclk);
		end
		last_waits[m] = n;
		last_rdata[m] = hrdata_m[m];
		last_resp[m]  = hresp_m[m];
	endtask

	task automatic m_write(input int m, input haddr_t addr, input hdata_t data, input logic lock);
		bus_xfer(m, addr, 1'b1, data, lock);
	endtask

	task automatic m_read(input int m, input haddr_t addr, input logic lock);
		bus_xfer(m, addr, 1'b0, '0, lock);
	endtask

	task automatic reset_state();
		@(negedge hclk);
		check_ready("reset", 2'b11, {hready_m[1], hready_m[0]});
		check_slots("reset", '0, hsel_s);
		check_resp("reset", HRESP_OKAY, hresp_m[0]);
		check_resp("reset", HRESP_OKAY, hresp_m[1]);
	endtask

	// All four writes go first so a wrong decode overwrites another slot
	task automatic slot_decode();
		for (int s = 0; s < NUM_SLOTS; s++) begin
			m_write(0, {4'(s), 28'h0000020}, 32'hd0d0_0000 + s, 1'b0);
			check_resp("decode", HRESP_OKAY, last_resp[0]);
		end
		for (int s = 0; s < NUM_SLOTS; s++) begin
			m_read(0, {4'(s), 28'h0000020}, 1'b0);
			check_data("decode", 32'hd0d0_0000 + s, last_rdata[0]);
			check_resp("decode", HRESP_OKAY, last_resp[0]);
		end
	endtask

	task automatic default_slave();
		m_read(1, 32'h3000_0010, 1'b0);   // Slot 3 is closed to master 1
		check_resp("default slot 3", HRESP_ERROR, first_resp[1]);
		check_resp("default slot 3", HRESP_ERROR, last_resp[1]);
		check_cycles("default slot 3", 1, last_waits[1]);
		m_write(1, 32'h7000_0010, 32'hdead_0007, 1'b0);   // No slot 7 in the map
		check_resp("default slot 7", HRESP_ERROR, first_resp[1]);
		check_resp("default slot 7", HRESP_ERROR, last_resp[1]);
		check_cycles("default slot 7", 1, last_waits[1]);
	endtask

	task automatic remap_swap();
		@(posedge hclk);
		#1;
		remap_m0 = 1'b1;
		m_write(0, 32'h0000_0200, 32'h5a5a_0001, 1'b0);
		check_resp("remap", HRESP_OKAY, last_resp[0]);
		@(posedge hclk);
		#1;
		remap_m0 = 1'b0;
		m_read(1, 32'h1000_0200, 1'b0);
		check_data("remap", 32'h5a5a_0001, last_rdata[1]);
		check_resp("remap", HRESP_OKAY, last_resp[1]);
	endtask

	task automatic contention();
		fork
			m_write(0, 32'h2000_0100, 32'hc0c0_0000, 1'b0);
			m_write(1, 32'h2000_0104, 32'hc1c1_0001, 1'b0);
		join
		check_resp("contention", HRESP_OKAY, last_resp[0]);
		check_resp("contention", HRESP_OKAY, last_resp[1]);
		m_read(0, 32'h2000_0100, 1'b0);
		check_data("contention", 32'hc0c0_0000, last_rdata[0]);
		m_read(0, 32'h2000_0104, 1'b0);
		check_data("contention", 32'hc1c1_0001, last_rdata[0]);
	endtask

	task automatic locked_access();
		int n;
		int k;
		lock_held = 1'b0;
		fork
			begin
				m_read(0, 32'h2000_0080, 1'b1);
				check_data("lock", 32'hc0de_0080, last_rdata[0]);   // Unwritten fill word
				lock_held = 1'b1;
				k = 0;
				while (htrans_m[1] != HTRANS_NONSEQ) begin   // Master 1 asks inside the lock
					k++;
					if (k > TIMEOUT) abort_run("master 1 never started its write");
					@(negedge hclk);
				end
				m_write(0, 32'h2000_0080, 32'h1000_00a0, 1'b1);
				@(posedge hclk);
				#1;
				hmastlock_m[0] = 1'b0;
			end
			begin
				n = 0;
				while (!lock_held) begin
					n++;
					if (n > TIMEOUT) abort_run("master 0 never took the lock");
					@(posedge hclk);
				end
				m_write(1, 32'h2000_0080, 32'h1100_00b1, 1'b0);
				check_resp("lock", HRESP_OKAY, last_resp[1]);
			end
		join
		m_read(0, 32'h2000_0080, 1'b0);
		check_data("lock", 32'h1100_00b1, last_rdata[0]);   // Master 1 wrote last
	endtask

	initial begin
		rst_n     = 1'b0;
		remap_m0  = 1'b0;
		lock_held = 1'b0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			haddr_m[m]     = '0;
			htrans_m[m]    = HTRANS_IDLE;
			hwrite_m[m]    = 1'b0;
			hsize_m[m]     = 3'b010;   // Word
			hburst_m[m]    = 3'b000;   // SINGLE
			hmastlock_m[m] = 1'b0;
			hwdata_m[m]    = '0;
		end
		repeat (5) @(posedge hclk);
		#1;
		rst_n = 1'b1;
		reset_state();
		slot_decode();
		default_slave();
		remap_swap();
		contention();
		locked_access();
		@(posedge hclk);
		$display("Checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- verif/ahbl_mem_slave.sv
//**********************************************************************
// Behavioural AHB-Lite memory slave for the matrix testbench.
// 256 words addressed by HADDR[9:2]; only word transfers are modelled.
// Wait states come from the wait_states input, taken with the address.
// Unwritten words read as 0xc0de in the upper half and the byte address
// of the word in the lower half. HRESP is always OKAY.
//**********************************************************************
`timescale 1ns/1ps

module ahbl_mem_slave (
	input  logic                  hclk,
	input  logic                  rst_n,
	input  logic                  hsel,
	input  ahbl_bus_pkg::haddr_t  haddr,
	input  ahbl_bus_pkg::htrans_t htrans,
	input  logic                  hwrite,
	input  ahbl_bus_pkg::hdata_t  hwdata,
	input  logic                  hready,
	input  logic [1:0]            wait_states,
	output ahbl_bus_pkg::hdata_t  hrdata,
	output logic                  hreadyout,
	output ahbl_bus_pkg::hresp_t  hresp
);
	import ahbl_bus_pkg::*;

	hdata_t     mem [256];
	logic       d_act;      // Data phase in progress
	logic       d_write;
	logic [7:0] d_idx;
	logic [1:0] wait_q;     // Wait states left in this data phase
	logic       take;

	initial begin
		for (int i = 0; i < 256; i++) begin
			mem[i] = {16'hc0de, 6'd0, 8'(i), 2'b00};
		end
	end

	assign take      = hsel && hready && htrans[1];   // NONSEQ or SEQ
	assign hreadyout = (wait_q == 2'd0);
	assign hresp     = HRESP_OKAY;
	assign hrdata    = (d_act && !d_write) ? mem[d_idx] : '0;

	always @(posedge hclk) begin
		if (!rst_n) begin
			d_act   <= 1'b0;
			d_write <= 1'b0;
			d_idx   <= '0;
			wait_q  <= '0;
		end else if (wait_q != 2'd0) begin
			wait_q <= wait_q - 2'd1;
		end else begin
			if (d_act && d_write) begin
				mem[d_idx] <= hwdata;   // Write lands as the data phase ends
			end
			d_act   <= take;
			d_write <= hwrite;
			d_idx   <= haddr[9:2];
			wait_q  <= take ? wait_states : 2'd0;
		end
	end

endmodule

//--- rtl/ahbl_matrix.sv
//********************************************************************
// Two-master, four-slot AHB-Lite bus matrix.
// Slot n of the slave arrays answers the address nibble n.
// Remap is offered to master 0 only. HPROT is not carried.
// Reset is synchronous and active low.
//********************************************************************
`timescale 1ns/1ps

module ahbl_matrix (
	input  logic                          hclk,
	input  logic                          rst_n,
	input  logic                          remap_m0,
	input  ahbl_bus_pkg::haddr_t          haddr_m0,
	input  ahbl_bus_pkg::htrans_t         htrans_m0,
	input  logic                          hwrite_m0,
	input  ahbl_bus_pkg::hsize_t          hsize_m0,
	input  ahbl_bus_pkg::hburst_t         hburst_m0,
	input  logic                          hmastlock_m0,
	input  ahbl_bus_pkg::hdata_t          hwdata_m0,
	output ahbl_bus_pkg::hdata_t          hrdata_m0,
	output logic                          hready_m0,
	output ahbl_bus_pkg::hresp_t          hresp_m0,
	input  ahbl_bus_pkg::haddr_t          haddr_m1,
	input  ahbl_bus_pkg::htrans_t         htrans_m1,
	input  logic                          hwrite_m1,
	input  ahbl_bus_pkg::hsize_t          hsize_m1,
	input  ahbl_bus_pkg::hburst_t         hburst_m1,
	input  logic                          hmastlock_m1,
	input  ahbl_bus_pkg::hdata_t          hwdata_m1,
	output ahbl_bus_pkg::hdata_t          hrdata_m1,
	output logic                          hready_m1,
	output ahbl_bus_pkg::hresp_t          hresp_m1,
	output wire ahbl_map_pkg::slot_vec_t  hsel_s,
	output ahbl_bus_pkg::haddr_t          haddr_s [ahbl_map_pkg::NUM_SLOTS],
	output ahbl_bus_pkg::htrans_t         htrans_s [ahbl_map_pkg::NUM_SLOTS],
	output wire ahbl_map_pkg::slot_vec_t  hwrite_s,
	output ahbl_bus_pkg::hsize_t          hsize_s [ahbl_map_pkg::NUM_SLOTS],
	output ahbl_bus_pkg::hburst_t         hburst_s [ahbl_map_pkg::NUM_SLOTS],
	output wire ahbl_map_pkg::slot_vec_t  hmastlock_s,
	output ahbl_bus_pkg::hdata_t          hwdata_s [ahbl_map_pkg::NUM_SLOTS],
	output wire ahbl_map_pkg::slot_vec_t  hready_s,
	input  ahbl_bus_pkg::hdata_t          hrdata_s [ahbl_map_pkg::NUM_SLOTS],
	input  ahbl_map_pkg::slot_vec_t       hreadyout_s,
	input  ahbl_bus_pkg::hresp_t          hresp_s [ahbl_map_pkg::NUM_SLOTS]
);
	import ahbl_bus_pkg::*;
	import ahbl_map_pkg::*;

	// Master ports gathered into arrays, index is the master number
	haddr_t  m_haddr [NUM_MASTERS];
	htrans_t m_htrans [NUM_MASTERS];
	hsize_t  m_hsize [NUM_MASTERS];
	hburst_t m_hburst [NUM_MASTERS];
	hdata_t  m_hwdata [NUM_MASTERS];
	hdata_t  m_hrdata [NUM_MASTERS];
	hresp_t  m_hresp [NUM_MASTERS];
	wire master_vec_t m_remap = {1'b0, remap_m0};   // No remap for master 1
	wire master_vec_t m_hwrite = {hwrite_m1, hwrite_m0};
	wire master_vec_t m_hmastlock = {hmastlock_m1, hmastlock_m0};
	wire master_vec_t m_hready;

	// Held address phases broadcast to all slave stages
	haddr_t  a_haddr [NUM_MASTERS];
	htrans_t a_htrans [NUM_MASTERS];
	hsize_t  a_hsize [NUM_MASTERS];
	hburst_t a_hburst [NUM_MASTERS];
	hdata_t  a_hwdata [NUM_MASTERS];
	wire master_vec_t a_hwrite;
	wire master_vec_t a_hmastlock;

	wire slot_vec_t   m_req [NUM_MASTERS];
	wire slot_vec_t   m_grant [NUM_MASTERS];
	wire master_vec_t s_req [NUM_SLOTS];
	wire master_vec_t s_grant [NUM_SLOTS];

	assign m_haddr  = '{haddr_m0, haddr_m1};
	assign m_htrans = '{htrans_m0, htrans_m1};
	assign m_hsize  = '{hsize_m0, hsize_m1};
	assign m_hburst = '{hburst_m0, hburst_m1};
	assign m_hwdata = '{hwdata_m0, hwdata_m1};

	assign hrdata_m0 = m_hrdata[0];
	assign hready_m0 = m_hready[0];
	assign hresp_m0  = m_hresp[0];
	assign hrdata_m1 = m_hrdata[1];
	assign hready_m1 = m_hready[1];
	assign hresp_m1  = m_hresp[1];

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
		ahbl_master_stage u_master (
			.hclk        (hclk),
			.rst_n       (rst_n),
			.remap       (m_remap[m]),
			.slot_enable (M_SLOT_ENABLE[m]),
			.haddr       (m_haddr[m]),
			.htrans      (m_htrans[m]),
			.hwrite      (m_hwrite[m]),
			.hsize       (m_hsize[m]),
			.hburst      (m_hburst[m]),
			.hmastlock   (m_hmastlock[m]),
			.hwdata      (m_hwdata[m]),
			.hready      (m_hready[m]),
			.hresp       (m_hresp[m]),
			.hrdata      (m_hrdata[m]),
			.grant       (m_grant[m]),
			.s_hrdata    (hrdata_s),
			.s_hreadyout (hreadyout_s),
			.s_hresp     (hresp_s),
			.req         (m_req[m]),
			.a_haddr     (a_haddr[m]),
			.a_htrans    (a_htrans[m]),
			.a_hwrite    (a_hwrite[m]),
			.a_hsize     (a_hsize[m]),
			.a_hburst    (a_hburst[m]),
			.a_hmastlock (a_hmastlock[m]),
			.a_hwdata    (a_hwdata[m])
		);

		for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_xpose
			assign s_req[s][m]   = m_req[m][s];
			assign m_grant[m][s] = s_grant[s][m];
		end
	end

	for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slave
		ahbl_slave_stage u_slave (
			.hclk        (hclk),
			.rst_n       (rst_n),
			.req         (s_req[s]),
			.m_haddr     (a_haddr),
			.m_htrans    (a_htrans),
			.m_hwrite    (a_hwrite),
			.m_hsize     (a_hsize),
			.m_hburst    (a_hburst),
			.m_hmastlock (a_hmastlock),
			.m_hwdata    (a_hwdata),
			.hreadyout   (hreadyout_s[s]),
			.grant       (s_grant[s]),
			.hsel        (hsel_s[s]),
			.haddr       (haddr_s[s]),
			.htrans      (htrans_s[s]),
			.hwrite      (hwrite_s[s]),
			.hsize       (hsize_s[s]),
			.hburst      (hburst_s[s]),
			.hmastlock   (hmastlock_s[s]),
			.hwdata      (hwdata_s[s]),
			.hready      (hready_s[s])
		);
	end

endmodule

//--- rtl/ahbl_slave_stage.sv
//********************************************************************
// Slave-side stage of the matrix.
// Round-robin between the masters, starting after the last owner.
// While the owner keeps HMASTLOCK high no other master is granted.
// A SEQ beat that follows another master's transfer goes out as NONSEQ.
// The slave's HREADY input is its own HREADYOUT.
//********************************************************************
`timescale 1ns/1ps

module ahbl_slave_stage (
	input  logic                       hclk,
	input  logic                       rst_n,
	input  ahbl_map_pkg::master_vec_t  req,
	input  ahbl_bus_pkg::haddr_t       m_haddr [ahbl_map_pkg::NUM_MASTERS],
	input  ahbl_bus_pkg::htrans_t      m_htrans [ahbl_map_pkg::NUM_MASTERS],
	input  ahbl_map_pkg::master_vec_t  m_hwrite,
	input  ahbl_bus_pkg::hsize_t       m_hsize [ahbl_map_pkg::NUM_MASTERS],
	input  ahbl_bus_pkg::hburst_t      m_hburst [ahbl_map_pkg::NUM_MASTERS],
	input  ahbl_map_pkg::master_vec_t  m_hmastlock,
	input  ahbl_bus_pkg::hdata_t       m_hwdata [ahbl_map_pkg::NUM_MASTERS],
	input  logic                       hreadyout,
	output ahbl_map_pkg::master_vec_t  grant,
	output logic                       hsel,
	output ahbl_bus_pkg::haddr_t       haddr,
	output ahbl_bus_pkg::htrans_t      htrans,
	output logic                       hwrite,
	output ahbl_bus_pkg::hsize_t       hsize,
	output ahbl_bus_pkg::hburst_t      hburst,
	output logic                       hmastlock,
	output ahbl_bus_pkg::hdata_t       hwdata,
	output logic                       hready
);
	import ahbl_bus_pkg::*;
	import ahbl_map_pkg::*;

	master_idx_t owner_q;      // Last accepted master, owns the data phase
	logic        lock_q;       // Owner's last accepted transfer was locked
	logic        lock_active;
	master_idx_t win;
	logic        found;
	logic        accept;

	// Lock holds as long as the owner keeps HMASTLOCK up
	assign lock_active = lock_q & m_hmastlock[owner_q];

	always_comb begin
		win   = owner_q;
		found = 1'b0;
		if (lock_active) begin
			found = req[owner_q];
		end else begin
			for (int k = 1; k <= NUM_MASTERS; k++) begin
				if (!found && req[(int'(owner_q) + k) % NUM_MASTERS]) begin
					win   = master_idx_t'((int'(owner_q) + k) % NUM_MASTERS);
					found = 1'b1;
				end
			end
		end
	end

	// Address phase is taken only when the slave is ready
	assign accept = found & hreadyout;
	assign grant  = accept ? master_vec_t'(1) << win : '0;

	assign hsel      = found;
	assign haddr     = m_haddr[win];
	assign hwrite    = m_hwrite[win];
	assign hsize     = m_hsize[win];
	assign hburst    = m_hburst[win];
	assign hmastlock = m_hmastlock[win];

	always_comb begin
		htrans = HTRANS_IDLE;
		if (found) begin
			htrans = m_htrans[win];
			if (m_htrans[win] == HTRANS_SEQ && win != owner_q) begin
				htrans = HTRANS_NONSEQ;   // Burst broken by the other master
			end
		end
	end

	assign hwdata = m_hwdata[owner_q];
	assign hready = hreadyout;

	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			owner_q <= '0;
			lock_q  <= 1'b0;
		end else if (accept) begin
			owner_q <= win;
			lock_q  <= m_hmastlock[win];
		end else begin
			lock_q  <= lock_active;
		end
	end

	a_grant_onehot: assert property (@(posedge hclk) disable iff (!rst_n) $onehot0(grant))
		else $error("slave stage grants more than one master");

endmodule

//--- rtl/ahbl_master_stage.sv
//********************************************************************
// Master-side stage of the matrix.
// An address phase that is not granted at once is held here and the
// master sees HREADY low until its slave stage grants it.
// Disabled or unmapped slots get the two-cycle ERROR response.
// BUSY and IDLE are not forwarded to any slave.
//********************************************************************
`timescale 1ns/1ps

module ahbl_master_stage (
	input  logic                     hclk,
	input  logic                     rst_n,
	input  logic                     remap,
	input  ahbl_map_pkg::slot_vec_t  slot_enable,
	input  ahbl_bus_pkg::haddr_t     haddr,
	input  ahbl_bus_pkg::htrans_t    htrans,
	input  logic                     hwrite,
	input  ahbl_bus_pkg::hsize_t     hsize,
	input  ahbl_bus_pkg::hburst_t    hburst,
	input  logic                     hmastlock,
	input  ahbl_bus_pkg::hdata_t     hwdata,
	output logic                     hready,
	output ahbl_bus_pkg::hresp_t     hresp,
	output ahbl_bus_pkg::hdata_t     hrdata,
	input  ahbl_map_pkg::slot_vec_t  grant,
	input  ahbl_bus_pkg::hdata_t     s_hrdata [ahbl_map_pkg::NUM_SLOTS],
	input  ahbl_map_pkg::slot_vec_t  s_hreadyout,
	input  ahbl_bus_pkg::hresp_t     s_hresp [ahbl_map_pkg::NUM_SLOTS],
	output ahbl_map_pkg::slot_vec_t  req,
	output ahbl_bus_pkg::haddr_t     a_haddr,
	output ahbl_bus_pkg::htrans_t    a_htrans,
	output logic                     a_hwrite,
	output ahbl_bus_pkg::hsize_t     a_hsize,
	output ahbl_bus_pkg::hburst_t    a_hburst,
	output logic                     a_hmastlock,
	output ahbl_bus_pkg::hdata_t     a_hwdata
);
	import ahbl_bus_pkg::*;
	import ahbl_map_pkg::*;

	haddr_u    in_u;
	haddr_u    out_u;
	slot_id_t  slot_phys;
	slot_vec_t live_sel;
	logic      live_ok;
	logic      xfer;
	logic      accepted;

	logic      hold_q;      // Address phase waiting for a grant
	logic      err1_q;      // Default slave, first ERROR cycle
	logic      err2_q;      // Default slave, second ERROR cycle
	slot_vec_t d_sel;       // Slot owning the current data phase
	logic      d_ready;
	hresp_t    d_resp;

	haddr_t    h_haddr;
	htrans_t   h_htrans;
	logic      h_hwrite;
	hsize_t    h_hsize;
	hburst_t   h_hburst;
	logic      h_hmastlock;
	slot_vec_t h_sel;

	assign in_u.flat = haddr;

	// Remap swaps two slots and the slave sees the physical slot number
	always_comb begin
		slot_phys = in_u.field.slot;
		if (remap && in_u.field.slot == REMAP_SLOT_A) begin
			slot_phys = REMAP_SLOT_B;
		end else if (remap && in_u.field.slot == REMAP_SLOT_B) begin
			slot_phys = REMAP_SLOT_A;
		end
		out_u            = in_u;
		out_u.field.slot = slot_phys;
	end

	assign live_sel = (slot_phys < NUM_SLOTS) ? (slot_vec_t'(1) << slot_phys) & slot_enable : '0;
	assign live_ok  = |live_sel;
	assign xfer     = hready && (htrans != HTRANS_IDLE) && (htrans != HTRANS_BUSY);

	assign req      = hold_q ? h_sel : (xfer ? live_sel : '0);
	assign accepted = |(grant & req);

	// Held fields win over the live bus while a request is pending
	assign a_haddr     = hold_q ? h_haddr : out_u.flat;
	assign a_htrans    = hold_q ? h_htrans : htrans;
	assign a_hwrite    = hold_q ? h_hwrite : hwrite;
	assign a_hsize     = hold_q ? h_hsize : hsize;
	assign a_hburst    = hold_q ? h_hburst : hburst;
	assign a_hmastlock = hold_q ? h_hmastlock : hmastlock;
	assign a_hwdata    = hwdata;   // Master keeps it stable through the data phase

	always_ff @(posedge hclk) begin
		if (!rst_n) begin
			hold_q <= 1'b0;
			err1_q <= 1'b0;
			err2_q <= 1'b0;
			d_sel  <= '0;
		end else if (hold_q) begin
			if (accepted) begin
				hold_q <= 1'b0;
				d_sel  <= h_sel;
			end
		end else if (err1_q) begin
			err1_q <= 1'b0;
			err2_q <= 1'b1;
		end else if (hready) begin
			err2_q <= 1'b0;
			err1_q <= xfer & ~live_ok;
			hold_q <= xfer & live_ok & ~accepted;
			d_sel  <= accepted ? live_sel : '0;
		end
	end

	always_ff @(posedge hclk) begin
		if (!hold_q) begin   // Frozen while waiting
			h_haddr     <= out_u.flat;
			h_htrans    <= htrans;
			h_hwrite    <= hwrite;
			h_hsize     <= hsize;
			h_hburst    <= hburst;
			h_hmastlock <= hmastlock;
			h_sel       <= live_sel;
		end
	end

	// Return path from the data-phase slot
	always_comb begin
		hrdata = '0;
		d_resp = HRESP_OKAY;
		for (int s = 0; s < NUM_SLOTS; s++) begin
			if (d_sel[s]) begin
				hrdata = s_hrdata[s];
				d_resp = s_hresp[s];
			end
		end
	end

	assign d_ready = (d_sel == '0) || |(d_sel & s_hreadyout);
	assign hready  = ~hold_q & ~err1_q & d_ready;
	assign hresp   = (err1_q | err2_q) ? HRESP_ERROR : d_resp;

	a_req_onehot: assert property (@(posedge hclk) disable iff (!rst_n) $onehot0(req))
		else $error("master stage request is not one-hot");

	a_req_enabled: assert property (@(posedge hclk) disable iff (!rst_n)
		(req & ~slot_enable) == '0)
		else $error("master stage requests a disabled slot");

endmodule

//--- rtl/ahbl_map_pkg.sv
//********************************************************************
// Memory map of the two-master, four-slot matrix.
// Slot numbers above NUM_SLOTS-1 are unmapped and answer with ERROR.
// Remap only applies to master 0 and swaps the two slots named here.
//********************************************************************
package ahbl_map_pkg;

	import ahbl_bus_pkg::*;

	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLOTS   = 4;

	typedef logic [NUM_SLOTS-1:0]           slot_vec_t;     // One bit per slot
	typedef logic [NUM_MASTERS-1:0]         master_vec_t;   // One bit per master
	typedef logic [SLOT_W-1:0]              slot_id_t;      // Decoded address nibble
	typedef logic [$clog2(NUM_MASTERS)-1:0] master_idx_t;

	// Allowed slots per master, bit n is slot n
	localparam slot_vec_t M_SLOT_ENABLE [NUM_MASTERS] = '{
		4'b1111,   // Master 0 reaches every slot
		4'b0111    // Master 1 is kept out of slot 3
	};

	// Pair of slots swapped while remap is high
	localparam slot_id_t REMAP_SLOT_A = 4'd0;
	localparam slot_id_t REMAP_SLOT_B = 4'd1;

endpackage

//--- rtl/ahbl_bus_pkg.sv
//********************************************************************
// AHB-Lite bus types and encodings shared by every matrix block.
// HRESP is the one-bit AHB-Lite response, so only OKAY and ERROR exist.
// The slot field is the top address nibble and the rest is the offset.
//********************************************************************
package ahbl_bus_pkg;

	localparam int SLOT_W   = 4;           // Top nibble selects the slot
	localparam int OFFSET_W = 28;

	typedef logic [31:0] haddr_t;
	typedef logic [31:0] hdata_t;
	typedef logic [1:0]  htrans_t;
	typedef logic [2:0]  hsize_t;
	typedef logic [2:0]  hburst_t;
	typedef logic        hresp_t;

	localparam htrans_t HTRANS_IDLE   = 2'b00;
	localparam htrans_t HTRANS_BUSY   = 2'b01;
	localparam htrans_t HTRANS_NONSEQ = 2'b10;
	localparam htrans_t HTRANS_SEQ    = 2'b11;

	localparam hresp_t HRESP_OKAY  = 1'b0;
	localparam hresp_t HRESP_ERROR = 1'b1;

	typedef struct packed {
		logic [SLOT_W-1:0]   slot;
		logic [OFFSET_W-1:0] offset;
	} haddr_fields_t;

	// Same word seen flat by the slave, split by the decoder
	typedef union packed {
		haddr_t        flat;
		haddr_fields_t field;
	} haddr_u;

endpackage
